// File: vlog.f
rtl/matmul_pkg.sv
rtl/weight_unpack.sv
rtl/operand_buffer.sv
rtl/mac_array.sv
rtl/readout_queue.sv
rtl/e2m0_matmul_top.sv
dv/matmul_assertions.sv
dv/tb_matmul.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the matmul testbench with Verilator, assertions enabled.
# Exit status is 0 only when the log holds no fail message.
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_BIN=sim_matmul
LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_matmul -f vlog.f \
        -Mdir "$BUILD_DIR" -o "$SIM_BIN"; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/$SIM_BIN" +verilator+error+limit+1000 > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Simulation finished: FAIL" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
if [ "$sim_status" -ne 0 ]; then
    echo "simulator exited with status $sim_status"
    exit 1
fi

echo "simulation passed"
exit 0

// File: dv/tb_matmul.sv
`timescale 1ns/10ps
// Testbench for e2m0_matmul_top. Inputs change 2 ns after each rising edge
// and results are sampled at the same point. Every run starts on a phase-0
// edge and ends with at least 2*SLICES idle cycles, a readout strobe and
// 48 results. Expected results come from a model of the 5-7-7 weight rule.

module tb_matmul;

    logic                clk;
    logic                reset;
    logic [7:0]          weight_byte;
    matmul_pkg::act_t    activation;
    logic                readout;
    matmul_pkg::result_t result;

    int error_count;
    int cycle_count;
    // reset, 78 blocks over four runs, per run the idle gap, the strobe
    // and the result stream, the extra idle cycles, plus a margin
    int cycle_limit = 8 + 78 * matmul_pkg::SLICES
                    + 4 * (2 * matmul_pkg::SLICES + 1 + matmul_pkg::ACC_COUNT) + 6 + 100;

    // model accumulators, entry r*COLS+c
    int exp_acc [matmul_pkg::ACC_COUNT];

    // operands of the block about to be fed
    logic [7:0]       blk_code [matmul_pkg::SLICES];
    matmul_pkg::act_t blk_act  [matmul_pkg::SLICES];

    e2m0_matmul_top dut (
        .clk         (clk),
        .reset       (reset),
        .weight_byte (weight_byte),
        .activation  (activation),
        .readout     (readout),
        .result      (result)
    );

    bind e2m0_matmul_top matmul_assertions u_assertions (
        .clk         (clk),
        .reset       (reset),
        .readout     (readout),
        .weight_byte (weight_byte),
        .lanes       (lanes),
        .phase       (u_operand_buffer.phase),
        .result      (result)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin : watchdog
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Simulation finished: FAIL");
        $finish;
    end

    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    // weight of one digit in half steps, lane 2 is d0, lane 1 d1, lane 0 d2
    function automatic int digit_weight(input int code, input int lane);
        int digit;
        if (code >= matmul_pkg::VALID_CODES) begin
            return 0;
        end
        case (lane)
            2:       digit = code % 5;
            1:       digit = (code / 5) % 7;
            default: digit = code / 35;
        endcase
        if (lane == 2) begin
            case (digit)
                0:       return 0;
                1:       return 2;
                2:       return 4;
                3:       return -2;
                default: return -4;
            endcase
        end
        case (digit)
            0:       return 0;
            1:       return 1;
            2:       return 2;
            3:       return 4;
            4:       return -1;
            5:       return -2;
            default: return -4;
        endcase
    endfunction

    // w in half steps; halving floors toward minus infinity
    function automatic int scaled_term(input int w, input int a);
        int mag;
        int base;
        mag = (w < 0) ? -w : w;
        if (mag == 0) begin
            return 0;
        end
        if (mag == 1) begin
            base = a >>> 1;
        end else if (mag == 2) begin
            base = a;
        end else begin
            base = a * 2;
        end
        return (w < 0) ? -base : base;
    endfunction

    task automatic accumulate_block();
        int r;
        int w;
        for (int s = 0; s < matmul_pkg::SLICES; s++) begin
            for (int k = 0; k < matmul_pkg::LANES; k++) begin
                r = s * matmul_pkg::LANES + k;
                w = digit_weight(int'(blk_code[s]), k);
                for (int c = 0; c < matmul_pkg::COLS; c++) begin
                    exp_acc[r*matmul_pkg::COLS + c] += scaled_term(w, int'(blk_act[c]));
                end
            end
        end
    endtask

    task automatic clear_model();
        for (int n = 0; n < matmul_pkg::ACC_COUNT; n++) begin
            exp_acc[n] = 0;
        end
    endtask

    task automatic feed_block();
        accumulate_block();
        for (int s = 0; s < matmul_pkg::SLICES; s++) begin
            weight_byte = blk_code[s];
            activation  = blk_act[s];
            tick();
        end
    endtask

    task automatic set_block(input logic [7:0] code, input matmul_pkg::act_t act);
        for (int s = 0; s < matmul_pkg::SLICES; s++) begin
            blk_code[s] = code;
            blk_act[s]  = act;
        end
    endtask

    task automatic fill_random_block();
        for (int s = 0; s < matmul_pkg::SLICES; s++) begin
            blk_code[s] = 8'($urandom);
            blk_act[s]  = matmul_pkg::act_t'($urandom);
        end
    endtask

    // idle gap, strobe, then entry n is on result n cycles after the strobe edge
    // extra idle cycles move the strobe into another slice phase
    task automatic readout_and_check(input int extra_idle);
        matmul_pkg::result_t expected;
        weight_byte = '0;
        activation  = '0;
        repeat (2 * matmul_pkg::SLICES + extra_idle) tick();
        readout = 1'b1;
        tick();
        readout = 1'b0;
        for (int n = 0; n < matmul_pkg::ACC_COUNT; n++) begin
            expected = matmul_pkg::result_t'(exp_acc[n] >>> matmul_pkg::OUT_SHIFT);
            if (result !== expected) begin
                error_count++;
                $display("** Error at %0t ns: result expected 8'h%02h, got 8'h%02h (entry %0d)",
                         $time, expected, result, n);
            end
            tick();
        end
        clear_model();
    endtask

    initial begin : stimulus
        int assert_fails;
        void'($urandom(32'hc769f46e));
        error_count = 0;
        reset       = 1'b1;
        weight_byte = '0;
        activation  = '0;
        readout     = 1'b0;
        clear_model();
        repeat (8) tick();
        reset = 1'b0;

        // every code once, legal and illegal
        for (int b = 0; b < 256 / matmul_pkg::SLICES; b++) begin
            for (int s = 0; s < matmul_pkg::SLICES; s++) begin
                blk_code[s] = 8'(b * matmul_pkg::SLICES + s);
                blk_act[s]  = matmul_pkg::act_t'($urandom);
            end
            feed_block();
        end
        readout_and_check(0);

        for (int b = 0; b < 6; b++) begin
            fill_random_block();
            feed_block();
        end
        readout_and_check(1);

        // must see only these blocks after the previous readout
        for (int b = 0; b < 3; b++) begin
            fill_random_block();
            feed_block();
        end
        readout_and_check(2);

        // code 122 is +2,+2,+2 and 244 is -2,-2,-2, net -512 everywhere
        for (int b = 0; b < 4; b++) begin
            set_block((b == 2) ? 8'd244 : 8'd122, matmul_pkg::act_t'(-128));
            feed_block();
        end
        // half weights on odd negatives, floor moves -512 across a result step
        blk_code[0] = 8'd40;
        blk_code[1] = 8'd160;
        blk_code[2] = 8'd145;
        blk_code[3] = 8'd40;
        blk_act[0]  = matmul_pkg::act_t'(-1);
        blk_act[1]  = matmul_pkg::act_t'(-3);
        blk_act[2]  = matmul_pkg::act_t'(-127);
        blk_act[3]  = matmul_pkg::act_t'(-1);
        feed_block();
        readout_and_check(3);

        assert_fails = dut.u_assertions.fail_count;
        $display("errors: %0d result mismatches, %0d assertion failures",
                 error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: dv/matmul_assertions.sv
`timescale 1ns/10ps
// Checks bound into e2m0_matmul_top: decoder against the 5-7-7 rule,
// reset state, and the slice phase sequence.
// fail_count holds the number of failed checks so far.

module matmul_assertions (
    input logic                      clk,
    input logic                      reset,
    input logic                      readout,
    input logic [7:0]                weight_byte,
    input matmul_pkg::weight_lanes_t lanes,
    input matmul_pkg::phase_t        phase,
    input matmul_pkg::result_t       result
);

    int fail_count = 0;

    // digit value in half steps
    function automatic int half_steps(input int digit, input bit quinary);
        int v;
        if (quinary) begin
            v = (digit == 0) ? 0 : (digit == 1) ? 2 : (digit == 2) ? 4 :
                (digit == 3) ? -2 : -4;
        end else begin
            v = (digit == 0) ? 0 : (digit == 1) ? 1 : (digit == 2) ? 2 :
                (digit == 3) ? 4 : (digit == 4) ? -1 : (digit == 5) ? -2 : -4;
        end
        return v;
    endfunction

    function automatic matmul_pkg::weight_lanes_t expected_lanes(input logic [7:0] code);
        matmul_pkg::weight_lanes_t exp_l;
        int v [3];
        exp_l = '0;
        if (int'(code) >= matmul_pkg::VALID_CODES) begin
            exp_l.zero = '1;
            return exp_l;
        end
        v[2] = half_steps(int'(code) % 5, 1'b1);
        v[1] = half_steps((int'(code) / 5) % 7, 1'b0);
        v[0] = half_steps(int'(code) / 35, 1'b0);
        for (int k = 0; k < matmul_pkg::LANES; k++) begin
            exp_l.zero[k] = (v[k] == 0);
            exp_l.sign[k] = (v[k] < 0);
            exp_l.mul2[k] = (v[k] == 4) || (v[k] == -4);
            exp_l.div2[k] = (v[k] == 1) || (v[k] == -1);
        end
        return exp_l;
    endfunction

    reset_state: assert property (@(posedge clk) reset |=> (result == '0 && phase == '0))
        else begin fail_count++; $error("result or phase not cleared by reset"); end

    decode_rule: assert property (@(posedge clk) lanes == expected_lanes(weight_byte))
        else begin fail_count++; $error("decoder lanes break the 5-7-7 rule"); end

    illegal_zero: assert property (@(posedge clk)
        int'(weight_byte) >= matmul_pkg::VALID_CODES |->
            (lanes.zero == '1 && lanes.sign == '0 && lanes.mul2 == '0 && lanes.div2 == '0))
        else begin fail_count++; $error("illegal code gives nonzero weights"); end

    phase_step: assert property (@(posedge clk) disable iff (reset)
        (!readout && phase != matmul_pkg::phase_t'(matmul_pkg::SLICES - 1)) |=>
            phase == matmul_pkg::phase_t'($past(phase) + 1))
        else begin fail_count++; $error("phase did not advance by one"); end

    phase_wrap: assert property (@(posedge clk) disable iff (reset)
        (!readout && phase == matmul_pkg::phase_t'(matmul_pkg::SLICES - 1)) |=> phase == '0)
        else begin fail_count++; $error("phase did not wrap after the last slice"); end

    phase_restart: assert property (@(posedge clk) disable iff (reset)
        readout |=> phase == '0)
        else begin fail_count++; $error("phase not zero after readout"); end

endmodule

// File: rtl/e2m0_matmul_top.sv
`timescale 1ns/10ps
// Matmul top. One packed weight byte and one activation are consumed
// every cycle, with no back-pressure. Pulse readout at least 2*SLICES
// cycles after the last input of the final block; results then stream
// out one per cycle, entry n valid n+1 cycles after the readout edge.

module e2m0_matmul_top (
    input  logic                clk,
    input  logic                reset,
    input  logic [7:0]          weight_byte,
    input  matmul_pkg::act_t    activation,
    input  logic                readout,
    output matmul_pkg::result_t result
);

    matmul_pkg::weight_lanes_t                    lanes;
    matmul_pkg::row_ctl_t                         row_ctl;
    matmul_pkg::act_t                             act_cur;
    matmul_pkg::acc_t [matmul_pkg::ACC_COUNT-1:0] acc_next;

    weight_unpack u_weight_unpack (
        .code  (weight_byte),
        .lanes (lanes)
    );

    operand_buffer u_operand_buffer (
        .clk      (clk),
        .reset    (reset),
        .readout  (readout),
        .lanes_in (lanes),
        .act_in   (activation),
        .row_ctl  (row_ctl),
        .act_cur  (act_cur)
    );

    mac_array u_mac_array (
        .clk       (clk),
        .reset     (reset),
        .readout   (readout),
        .row_ctl   (row_ctl),
        .act_cur   (act_cur),
        .acc_state (),
        .acc_next  (acc_next)
    );

    readout_queue u_readout_queue (
        .clk      (clk),
        .reset    (reset),
        .readout  (readout),
        .acc_next (acc_next),
        .result   (result)
    );

endmodule

// File: rtl/readout_queue.sv
`timescale 1ns/10ps
// Output queue. On readout it snapshots the next accumulator state with
// the array rotation undone, so entry r*COLS+c is row r, column c, for a
// readout in any slice phase. Then it shifts toward entry 0, one per cycle.
// result is accumulator bits 16 to 9 of entry 0.

module readout_queue (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         readout,
    input  matmul_pkg::acc_t [matmul_pkg::ACC_COUNT-1:0] acc_next,
    output matmul_pkg::result_t                          result
);

    // local copy of the slice phase, gives the rotation offset of the array
    matmul_pkg::phase_t                           phase;
    matmul_pkg::acc_t [matmul_pkg::ACC_COUNT-1:0] queue;

    // physical slot that holds column c after this cycle's update
    function automatic int slot_of(input int c, input matmul_pkg::phase_t ph);
        return (c + 2 * matmul_pkg::COLS - 1 - int'(ph)) % matmul_pkg::COLS;
    endfunction

    always_ff @(posedge clk) begin
        if (reset || readout ||
            phase == matmul_pkg::phase_t'(matmul_pkg::SLICES - 1)) begin
            phase <= '0;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            queue <= '0;
        end else if (readout) begin
            for (int r = 0; r < matmul_pkg::ROWS; r++) begin
                for (int c = 0; c < matmul_pkg::COLS; c++) begin
                    queue[r*matmul_pkg::COLS + c] <=
                        acc_next[r*matmul_pkg::COLS + slot_of(c, phase)];
                end
            end
        end else begin
            // top entry holds its value
            queue <= {queue[matmul_pkg::ACC_COUNT-1], queue[matmul_pkg::ACC_COUNT-1:1]};
        end
    end

    assign result = matmul_pkg::result_t'(queue[0] >>> matmul_pkg::OUT_SHIFT);

endmodule

// File: rtl/mac_array.sv
`timescale 1ns/10ps
// ROWS x COLS accumulator strip. Only column 0 of each row has an adder.
// Every row rotates one slot per cycle toward slot 0, and the updated
// slot 0 value re-enters at slot COLS-1, so every column meets the
// adder once per block. Accumulators clear on reset and on readout.

module mac_array (
    input  logic                                         clk,
    input  logic                                         reset,
    input  logic                                         readout,
    input  matmul_pkg::row_ctl_t                         row_ctl,
    input  matmul_pkg::act_t                             act_cur,
    output matmul_pkg::acc_t [matmul_pkg::ACC_COUNT-1:0] acc_state,
    output matmul_pkg::acc_t [matmul_pkg::ACC_COUNT-1:0] acc_next
);

    matmul_pkg::addend_t act_ext;

    // sign extend before any shift so halving floors correctly
    assign act_ext = matmul_pkg::addend_t'(act_cur);

    for (genvar r = 0; r < matmul_pkg::ROWS; r++) begin : g_row
        localparam int BASE = r * matmul_pkg::COLS;

        matmul_pkg::addend_t addend;

        // scale by 2, 1/2 or 1, -128 * 2 still fits in nine bits
        assign addend = row_ctl.mul2[r] ? (act_ext <<< 1) :
                        row_ctl.div2[r] ? (act_ext >>> 1) :
                                          act_ext;

        // slot 0 is the only one that accumulates
        assign acc_next[BASE + matmul_pkg::COLS - 1] =
            row_ctl.zero[r] ? acc_state[BASE] :
            row_ctl.sign[r] ? acc_state[BASE] - addend :
                              acc_state[BASE] + addend;

        for (genvar p = 1; p < matmul_pkg::COLS; p++) begin : g_rotate
            assign acc_next[BASE + p - 1] = acc_state[BASE + p];
        end
    end

    always_ff @(posedge clk) begin
        if (reset || readout) begin
            acc_state <= '0;
        end else begin
            acc_state <= acc_next;
        end
    end

endmodule

// File: rtl/operand_buffer.sv
`timescale 1ns/10ps
// Slice phase counter and double-buffered weights and activations.
// A block of SLICES inputs fills the next buffer while the previous block,
// committed in each phase-0 cycle, drives the array. Readout restarts the phase.
// Input slot s feeds rows LANES*s to LANES*s+LANES-1 and activation column s.

module operand_buffer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      readout,
    input  matmul_pkg::weight_lanes_t lanes_in,
    input  matmul_pkg::act_t          act_in,
    output matmul_pkg::row_ctl_t      row_ctl,
    output matmul_pkg::act_t          act_cur
);

    matmul_pkg::phase_t                                 phase;
    matmul_pkg::weight_lanes_t [matmul_pkg::SLICES-1:0] next_w;
    matmul_pkg::weight_lanes_t [matmul_pkg::SLICES-1:0] cur_w;
    matmul_pkg::act_t          [matmul_pkg::SLICES-1:0] next_act;
    matmul_pkg::act_t          [matmul_pkg::SLICES-1:0] cur_act;

    always_ff @(posedge clk) begin
        if (reset || readout ||
            phase == matmul_pkg::phase_t'(matmul_pkg::SLICES - 1)) begin
            phase <= '0;
        end else begin
            phase <= phase + 1'b1;
        end
    end

    // newest input enters at the top, slot 0 ends up at index 0
    always_ff @(posedge clk) begin
        if (reset) begin
            next_w   <= '0;
            next_act <= '0;
        end else begin
            next_w   <= {lanes_in, next_w[matmul_pkg::SLICES-1:1]};
            next_act <= {act_in, next_act[matmul_pkg::SLICES-1:1]};
        end
    end

    // commit on phase 0; activations are pre-rotated by one so that
    // columns 1,2,..,0 reach the array in phases 1,2,..,0
    always_ff @(posedge clk) begin
        if (reset) begin
            cur_w   <= '0;
            cur_act <= '0;
        end else if (phase == '0) begin
            cur_w   <= next_w;
            cur_act <= {next_act[0], next_act[matmul_pkg::SLICES-1:1]};
        end else begin
            cur_act <= {cur_act[0], cur_act[matmul_pkg::SLICES-1:1]};
        end
    end

    // row LANES*s+k takes lane bit k of slot s
    always_comb begin
        for (int s = 0; s < matmul_pkg::SLICES; s++) begin
            for (int k = 0; k < matmul_pkg::LANES; k++) begin
                row_ctl.zero[s*matmul_pkg::LANES + k] = cur_w[s].zero[k];
                row_ctl.sign[s*matmul_pkg::LANES + k] = cur_w[s].sign[k];
                row_ctl.mul2[s*matmul_pkg::LANES + k] = cur_w[s].mul2[k];
                row_ctl.div2[s*matmul_pkg::LANES + k] = cur_w[s].div2[k];
            end
        end
    end

    assign act_cur = cur_act[0];

endmodule

// File: rtl/weight_unpack.sv
`timescale 1ns/10ps
// Combinational 5-7-7 weight decoder, code = d0 + 5*d1 + 35*d2.
// Lane 2 holds d0 (0,1,2,-1,-2), lanes 1 and 0 hold d1 and d2
// (0,1/2,1,2,-1/2,-1,-2). Codes at or above VALID_CODES give zero weights.

module weight_unpack (
    input  logic [7:0]                code,
    output matmul_pkg::weight_lanes_t lanes
);

    logic [2:0] d0;
    logic [2:0] d1;
    logic [2:0] d2;
    logic [3:0] f0;
    logic [3:0] f1;
    logic [3:0] f2;

    // flags of one digit as {zero, sign, mul2, div2}
    function automatic logic [3:0] digit_flags(input logic [2:0] digit,
                                               input logic       septenary);
        logic [3:0] flags;
        flags    = '0;
        flags[3] = (digit == 3'd0);
        if (septenary) begin
            flags[2] = (digit >= 3'd4);
            flags[1] = (digit == 3'd3) || (digit == 3'd6);
            flags[0] = (digit == 3'd1) || (digit == 3'd4);
        end else begin
            // quinary digit has no half step
            flags[2] = (digit >= 3'd3);
            flags[1] = (digit == 3'd2) || (digit == 3'd4);
        end
        return flags;
    endfunction

    // mixed radix split, constant divisors only
    assign d0 = 3'(code % 8'd5);
    assign d1 = 3'((code / 8'd5) % 8'd7);
    assign d2 = 3'(code / 8'd35);

    assign f0 = digit_flags(d0, 1'b0);
    assign f1 = digit_flags(d1, 1'b1);
    assign f2 = digit_flags(d2, 1'b1);

    always_comb begin
        if (code >= 8'(matmul_pkg::VALID_CODES)) begin
            lanes.zero = '1;
            lanes.sign = '0;
            lanes.mul2 = '0;
            lanes.div2 = '0;
        end else begin
            lanes.zero = {f0[3], f1[3], f2[3]};
            lanes.sign = {f0[2], f1[2], f2[2]};
            lanes.mul2 = {f0[1], f1[1], f2[1]};
            lanes.div2 = {f0[0], f1[0], f2[0]};
        end
    end

endmodule

// File: rtl/matmul_pkg.sv
// Shared geometry, widths and types of the low-precision weight matmul.
// SLICES sets the block length and the number of activation columns.
// Keep SLICES a power of two. Accumulators wrap silently after
// about 512 full-scale blocks.
package matmul_pkg;

    // array geometry
    localparam int SLICES      = 4;
    localparam int LANES       = 3;
    localparam int ROWS        = LANES * SLICES;
    localparam int COLS        = SLICES;
    localparam int ACC_COUNT   = ROWS * COLS;

    // datapath widths and output scaling
    localparam int ACC_W       = 18;
    localparam int OUT_SHIFT   = 9;

    // 5 * 7 * 7 legal packed weight bytes
    localparam int VALID_CODES = 245;

    typedef logic signed [7:0]           act_t;
    typedef logic signed [8:0]           addend_t;
    typedef logic signed [ACC_W-1:0]     acc_t;
    typedef logic        [7:0]           result_t;
    typedef logic [$clog2(SLICES)-1:0]   phase_t;
    typedef logic [LANES-1:0]            lane_mask_t;

    // one decoded weight byte, bit k of each mask is lane k
    typedef struct packed {
        lane_mask_t zero;
        lane_mask_t sign;
        lane_mask_t mul2;
        lane_mask_t div2;
    } weight_lanes_t;

    // current weights of every row in the strip
    typedef struct packed {
        logic [ROWS-1:0] zero;
        logic [ROWS-1:0] sign;
        logic [ROWS-1:0] mul2;
        logic [ROWS-1:0] div2;
    } row_ctl_t;

endpackage
